//--- sources.f
rtl/cache_geometry_pkg.sv
rtl/cache_tag_pkg.sv
rtl/tag_array.sv
rtl/line_ram.sv
rtl/read_response.sv
rtl/l1_cache.sv
verif/l1_cache_checker.sv
verif/l1_cache_tb.sv

//--- verif/l1_cache_tb.sv
//**************************************************
// L1 cache testbench
// Directed tests against a reference model of tags,
// recency status and line data
//**************************************************
`timescale 1ns/100ps

module l1_cache_tb
	import cache_geometry_pkg::*;
	import cache_tag_pkg::*;
();

	localparam int   IDLE_CYCLES     = 65600;	// More than one timer wrap
	localparam int   DIRECTED_CYCLES = 300;
	localparam int   MAX_CYCLES      = 70000 + DIRECTED_CYCLES;
	localparam tag_t SET_TAGS [5]    = '{22'h0A000, 22'h0B000, 22'h0C000, 22'h0D000, 22'h0E000};

	logic  iCLOCK;
	logic  inRESET;
	logic  iREMOVE;
	logic  iRD_REQ;
	logic  oRD_BUSY;
	addr_t iRD_ADDR;
	logic  oRD_VALID;
	logic  oRD_HIT;
	logic  iRD_BUSY;
	word_t oRD_DATA;
	logic  iWR_REQ;
	addr_t iWR_ADDR;
	line_t iWR_DATA;

	integer seed = 32'h19117441;
	int     cycle_count = 0;

	// Reference model state
	line_status_e           m_status [SETS][WAYS];
	tag_t                   m_tag    [SETS][WAYS];
	line_t                  m_line   [SETS][WAYS];
	logic [AGE_TIMER_W-1:0] m_timer;

	l1_cache l1_cache_i (.*);

	bind l1_cache l1_cache_checker l1_cache_checker_i (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.rd_busy  (iRD_BUSY),
		.rd_valid (oRD_VALID),
		.rd_hit   (oRD_HIT),
		.rd_data  (oRD_DATA)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;	// 100 ns period
	end

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compare_hit(logic actual, logic expected, string what);
		if (actual !== expected) begin
			fail_run($sformatf("Error at %0d ns: %s is %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	task automatic compare_word(word_t actual, word_t expected, string what);
		if (actual !== expected) begin
			fail_run($sformatf("Error at %0d ns: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic compare_way(way_t actual, way_t expected, string what);
		if (actual !== expected) begin
			fail_run($sformatf("Error at %0d ns: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	function automatic addr_t make_addr(tag_t tag, index_t idx, word_sel_t word);
		return {tag, idx, word, 3'b000};
	endfunction

	function automatic line_t rand_line();
		line_t l;
		for (int i = 0; i < LINE_W / 32; i++) begin
			l[i*32 +: 32] = $random(seed);
		end
		return l;
	endfunction

	// Tag compare against valid lines of the model
	function automatic logic model_hit(addr_t addr, output way_t way);
		way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (m_status[addr[9:6]][w] != LINE_INVALID && m_tag[addr[9:6]][w] == addr[31:10]) begin
				way = way_t'(w);
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function automatic word_t expected_word(addr_t addr);
		way_t way;
		if (!model_hit(addr, way)) begin
			return '0;	// Miss reads as zero
		end
		return m_line[addr[9:6]][way][addr[5:3]*WORD_W +: WORD_W];
	endfunction

	// Matching tag first, then the first way of lowest status or way 3 if all fresh
	function automatic way_t pick_way(index_t idx, tag_t tag);
		line_status_e low;
		low = LINE_FRESH;
		for (int w = 0; w < WAYS; w++) begin
			if (m_status[idx][w] != LINE_INVALID && m_tag[idx][w] == tag) begin
				return way_t'(w);
			end
		end
		for (int w = 0; w < WAYS; w++) begin
			if (m_status[idx][w] < low) begin
				low = m_status[idx][w];
			end
		end
		if (low == LINE_FRESH) begin
			return way_t'(WAYS - 1);
		end
		for (int w = 0; w < WAYS; w++) begin
			if (m_status[idx][w] == low) begin
				return way_t'(w);
			end
		end
		return '0;
	endfunction

	// Model update on each edge with fill before touch and ageing
	always @(posedge iCLOCK or negedge inRESET) begin : ref_model
		logic   wrap;
		way_t   way;
		index_t idx;
		if (!inRESET || iREMOVE) begin
			m_timer = '0;
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					m_status[s][w] = LINE_INVALID;
					m_tag[s][w]    = '0;
				end
			end
		end
		else begin
			wrap = !iRD_BUSY && (m_timer == '1);
			if (!iRD_BUSY) begin
				m_timer = m_timer + 1'b1;	// Frozen under back-pressure
			end
			if (iWR_REQ) begin
				idx                = iWR_ADDR[9:6];
				way                = pick_way(idx, iWR_ADDR[31:10]);
				m_status[idx][way] = LINE_FRESH;
				m_tag[idx][way]    = iWR_ADDR[31:10];
				m_line[idx][way]   = iWR_DATA;
			end
			else if (!iRD_BUSY) begin
				for (int s = 0; s < SETS && wrap; s++) begin
					for (int w = 0; w < WAYS; w++) begin
						case (m_status[s][w])
							LINE_FRESH: m_status[s][w] = LINE_AGED;
							LINE_AGED:  m_status[s][w] = LINE_OLD;
							default:    m_status[s][w] = m_status[s][w];
						endcase
					end
				end
				if (iRD_REQ && model_hit(iRD_ADDR, way)) begin
					m_status[iRD_ADDR[9:6]][way] = LINE_FRESH;	// Hit line back to fresh
				end
			end
		end
	end

	always @(posedge iCLOCK) begin
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			fail_run($sformatf("Timeout: the run went past %0d clock cycles", MAX_CYCLES));
		end
	end

	// Next drive point 10 ns after the edge
	task automatic tick();
		@(posedge iCLOCK);
		#10;
	endtask

	task automatic fill_line(addr_t addr, line_t line, way_t want_way);
		if (pick_way(addr[9:6], addr[31:10]) !== want_way) begin
			fail_run("Reference model chose a different fill way than the test expects");
		end
		iWR_REQ  = 1'b1;
		iWR_ADDR = addr;
		iWR_DATA = line;
		#1;
		compare_way(l1_cache_i.fill_way, want_way, "fill way");
		tick();
		iWR_REQ = 1'b0;
	endtask

	task automatic read_check(addr_t addr, logic want_hit);
		way_t  way;
		word_t exp_word;
		if (model_hit(addr, way) !== want_hit) begin
			fail_run("Reference model disagrees with the hit the test expects");
		end
		exp_word = expected_word(addr);
		iRD_REQ  = 1'b1;
		iRD_ADDR = addr;
		tick();	// Result one cycle later
		compare_hit(oRD_VALID, 1'b1, "oRD_VALID");
		compare_hit(oRD_HIT, want_hit, "oRD_HIT");
		compare_word(oRD_DATA, exp_word, "oRD_DATA");
		iRD_REQ = 1'b0;
	endtask

	task automatic cold_miss();
		read_check(make_addr(22'h00001, 4'd0, 3'd0), 1'b0);
		read_check(make_addr(22'h2ABCD, 4'd7, 3'd5), 1'b0);
		read_check(make_addr(22'h3FFFF, 4'd15, 3'd7), 1'b0);
	endtask

	task automatic fill_then_hit();
		fill_line(make_addr(22'h01234, 4'd1, 3'd0), rand_line(), 2'd0);
		for (int w = 0; w < 8; w++) begin
			read_check(make_addr(22'h01234, 4'd1, word_sel_t'(w)), 1'b1);	// Every word offset
		end
	endtask

	task automatic replacement();
		for (int i = 0; i < 4; i++) begin
			fill_line(make_addr(SET_TAGS[i], 4'd5, 3'd0), rand_line(), way_t'(i));
		end
		fill_line(make_addr(SET_TAGS[4], 4'd5, 3'd0), rand_line(), 2'd3);	// All fresh so D goes out
		for (int i = 0; i < 5; i++) begin
			read_check(make_addr(SET_TAGS[i], 4'd5, word_sel_t'(i)), i != 3);
		end
		fill_line(make_addr(SET_TAGS[0], 4'd5, 3'd0), rand_line(), 2'd0);	// In place
		read_check(make_addr(SET_TAGS[0], 4'd5, 3'd6), 1'b1);
	endtask

	task automatic remove_all();
		iREMOVE = 1'b1;
		tick();
		iREMOVE = 1'b0;
		read_check(make_addr(22'h01234, 4'd1, 3'd2), 1'b0);
		for (int i = 0; i < 5; i++) begin
			read_check(make_addr(SET_TAGS[i], 4'd5, 3'd1), 1'b0);
		end
	endtask

	task automatic ageing();
		for (int i = 0; i < 4; i++) begin
			fill_line(make_addr(SET_TAGS[i], 4'd12, 3'd0), rand_line(), way_t'(i));
		end
		repeat (IDLE_CYCLES) tick();	// Timer wrap ages all four
		read_check(make_addr(SET_TAGS[2], 4'd12, 3'd3), 1'b1);
		fill_line(make_addr(SET_TAGS[4], 4'd12, 3'd0), rand_line(), 2'd0);
		for (int i = 0; i < 5; i++) begin
			read_check(make_addr(SET_TAGS[i], 4'd12, 3'd7), i != 0);
		end
	endtask

	task automatic back_pressure();
		addr_t addr;
		word_t exp_word;
		addr = make_addr(22'h15555, 4'd9, 3'd4);
		fill_line(addr, rand_line(), 2'd0);
		exp_word = expected_word(addr);
		iRD_REQ  = 1'b1;
		iRD_ADDR = addr;
		tick();
		iRD_REQ  = 1'b0;
		iRD_ADDR = make_addr(22'h2AAAA, 4'd3, 3'd1);	// Must not reach the held read
		iRD_BUSY = 1'b1;
		repeat (3) begin
			#1;
			compare_hit(oRD_VALID, 1'b0, "oRD_VALID under back-pressure");
			compare_hit(oRD_BUSY, 1'b1, "oRD_BUSY under back-pressure");
			tick();
		end
		iRD_BUSY = 1'b0;
		#1;
		compare_hit(oRD_VALID, 1'b1, "held oRD_VALID");	// Held read comes out
		compare_hit(oRD_HIT, 1'b1, "held oRD_HIT");
		compare_word(oRD_DATA, exp_word, "held oRD_DATA");
		tick();
		// Read and fill of one address
		iRD_REQ  = 1'b1;
		iRD_ADDR = addr;
		iWR_REQ  = 1'b1;
		iWR_ADDR = addr;
		iWR_DATA = rand_line();
		#1;
		compare_hit(oRD_BUSY, 1'b1, "oRD_BUSY on read and fill collision");
		tick();
		iWR_ADDR = make_addr(22'h15555, 4'd10, 3'd4);	// Other set so no collision
		#1;
		compare_hit(oRD_BUSY, 1'b0, "oRD_BUSY on distinct addresses");
		tick();
		iRD_REQ = 1'b0;
		iWR_REQ = 1'b0;
	endtask

	initial begin
		inRESET  = 1'b0;
		iREMOVE  = 1'b0;
		iRD_REQ  = 1'b0;
		iRD_ADDR = '0;
		iRD_BUSY = 1'b0;
		iWR_REQ  = 1'b0;
		iWR_ADDR = '0;
		iWR_DATA = '0;
		repeat (8) @(posedge iCLOCK);
		#10;
		inRESET = 1'b1;
		tick();
		compare_hit(oRD_VALID, 1'b0, "oRD_VALID after reset");
		compare_hit(oRD_HIT, 1'b0, "oRD_HIT after reset");
		compare_hit(oRD_BUSY, 1'b0, "oRD_BUSY after reset");
		cold_miss();
		fill_then_hit();
		replacement();
		remove_all();	// Also restarts the ageing timer
		ageing();
		back_pressure();
		tick();
		tick();
		if (l1_cache_i.l1_cache_checker_i.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end
		else begin
			fail_run("The bound checker reported failed assertions");
		end
	end

endmodule

//--- verif/l1_cache_checker.sv
//**************************************************
// L1 cache read port checker
// Concurrent assertions on read result protocol
//**************************************************
`timescale 1ns/100ps

module l1_cache_checker
	import cache_geometry_pkg::*;
(
	input logic  iCLOCK,
	input logic  inRESET,
	input logic  rd_busy,
	input logic  rd_valid,
	input logic  rd_hit,
	input word_t rd_data
);

	int unsigned fail_count = 0;	// Failed assertions so far

	// No result while the host stalls
	valid_under_busy: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		rd_busy |-> !rd_valid
	) else begin
		fail_count++;
		$error("Read result valid while back-pressure is high");
	end

	// Hit only with a valid result
	hit_needs_valid: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		rd_hit |-> rd_valid
	) else begin
		fail_count++;
		$error("Read hit without a valid result");
	end

	// Misses and idle cycles read as zero
	data_zero_on_miss: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!rd_hit |-> (rd_data == '0)
	) else begin
		fail_count++;
		$error("Read data not zero without a hit");
	end

endmodule

//--- rtl/l1_cache.sv
//**************************************************
// L1 read cache
// 4-way set-associative, 16 sets of 64-byte lines
// Lookup with latency 1, single-cycle line fill
//**************************************************
`timescale 1ns/100ps

module l1_cache
	import cache_geometry_pkg::*;
(
	input  logic  iCLOCK,
	input  logic  inRESET,
	input  logic  iREMOVE,
	// Read request
	input  logic  iRD_REQ,
	output logic  oRD_BUSY,
	input  addr_t iRD_ADDR,
	// Read result
	output logic  oRD_VALID,
	output logic  oRD_HIT,
	input  logic  iRD_BUSY,
	output word_t oRD_DATA,
	// Line fill
	input  logic  iWR_REQ,
	input  addr_t iWR_ADDR,
	input  line_t iWR_DATA
);

	// Address fields
	index_t    rd_index;
	tag_t      rd_tag;
	word_sel_t rd_word_sel;
	index_t    wr_index;
	tag_t      wr_tag;

	logic             hit;
	way_t             hit_way;
	way_t             fill_way;
	logic [WAYS-1:0]  way_wr_en;
	line_t [WAYS-1:0] way_lines;

	assign rd_tag      = iRD_ADDR[TAG_LSB +: TAG_W];
	assign rd_index    = iRD_ADDR[INDEX_LSB +: INDEX_W];
	assign rd_word_sel = iRD_ADDR[WORD_LSB +: WORD_SEL_W];
	assign wr_tag      = iWR_ADDR[TAG_LSB +: TAG_W];
	assign wr_index    = iWR_ADDR[INDEX_LSB +: INDEX_W];

	// Stall on host back-pressure or a read colliding with its own fill
	assign oRD_BUSY = iRD_BUSY || (iRD_REQ && iWR_REQ && (iRD_ADDR == iWR_ADDR));

	tag_array tag_array_i (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.iREMOVE  (iREMOVE),
		.rd_req   (iRD_REQ),
		.rd_busy  (iRD_BUSY),
		.rd_index (rd_index),
		.rd_tag   (rd_tag),
		.wr_req   (iWR_REQ),
		.wr_index (wr_index),
		.wr_tag   (wr_tag),
		.hit      (hit),
		.hit_way  (hit_way),
		.fill_way (fill_way)
	);

	// One data RAM per way
	for (genvar g = 0; g < WAYS; g++) begin : g_way
		assign way_wr_en[g] = iWR_REQ && (fill_way == way_t'(g));	// Fill way decode

		line_ram line_ram_i (
			.iCLOCK   (iCLOCK),
			.wr_en    (way_wr_en[g]),
			.wr_index (wr_index),
			.wr_line  (iWR_DATA),
			.rd_en    (!iRD_BUSY),
			.rd_index (rd_index),
			.rd_line  (way_lines[g])
		);
	end

	read_response read_response_i (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.iREMOVE   (iREMOVE),
		.rd_req    (iRD_REQ),
		.rd_busy   (iRD_BUSY),
		.hit       (hit),
		.hit_way   (hit_way),
		.word_sel  (rd_word_sel),
		.way_lines (way_lines),
		.valid     (oRD_VALID),
		.hit_out   (oRD_HIT),
		.data      (oRD_DATA)
	);

endmodule

//--- rtl/read_response.sv
//**************************************************
// Read response
// Holds hit, way and word offset of a lookup and
// picks the 64-bit word out of the way lines
//**************************************************
`timescale 1ns/100ps

module read_response
	import cache_geometry_pkg::*;
(
	input  logic                iCLOCK,
	input  logic                inRESET,
	input  logic                iREMOVE,
	// Lookup
	input  logic                rd_req,
	input  logic                rd_busy,
	input  logic                hit,
	input  way_t                hit_way,
	input  word_sel_t           word_sel,
	// RAM outputs of all ways
	input  line_t [WAYS-1:0]    way_lines,
	// Result
	output logic                valid,
	output logic                hit_out,
	output word_t               data
);

	logic      valid_q;		// Pending read
	logic      hit_q;
	way_t      way_q;
	word_sel_t word_sel_q;

	line_t sel_line;
	word_t sel_word;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			hit_q   <= 1'b0;
		end
		else if (iREMOVE) begin
			valid_q <= 1'b0;
			hit_q   <= 1'b0;
		end
		else if (!rd_busy) begin
			valid_q <= rd_req;
			hit_q   <= hit;
		end
	end

	// Same edge as the RAM read address
	always_ff @(posedge iCLOCK) begin
		if (!rd_busy) begin
			way_q      <= hit_way;
			word_sel_q <= word_sel;
		end
	end

	assign sel_line = way_lines[way_q];
	assign sel_word = sel_line[word_sel_q * WORD_W +: WORD_W];	// Address bits 5..3

	// Nothing leaves while the reader stalls
	assign valid   = valid_q && !rd_busy;
	assign hit_out = valid && hit_q;
	assign data    = hit_out ? sel_word : '0;	// Zero on miss

endmodule

//--- rtl/line_ram.sv
//**************************************************
// Line RAM
// Data store of one way, 16 lines of 512 bits,
// one write port and a registered read address
//**************************************************
`timescale 1ns/100ps

module line_ram
	import cache_geometry_pkg::*;
(
	input  logic   iCLOCK,
	// Write port
	input  logic   wr_en,
	input  index_t wr_index,
	input  line_t  wr_line,
	// Read port
	input  logic   rd_en,
	input  index_t rd_index,
	output line_t  rd_line
);

	line_t  mem [SETS];
	index_t rd_index_q;	// Held while rd_en is low

	// Whole line write
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			mem[wr_index] <= wr_line;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (rd_en) begin
			rd_index_q <= rd_index;
		end
	end

	// Data follows the address one cycle later
	assign rd_line = mem[rd_index_q];

endmodule

//--- rtl/tag_array.sv
//**************************************************
// Tag array
// Tag and status store of all sets and ways, hit
// check, fill way choice, ageing timer and the
// recency updates on fill, read hit and timer wrap
//**************************************************
`timescale 1ns/100ps

module tag_array
	import cache_geometry_pkg::*;
	import cache_tag_pkg::*;
(
	input  logic   iCLOCK,
	input  logic   inRESET,
	input  logic   iREMOVE,
	// Lookup side
	input  logic   rd_req,
	input  logic   rd_busy,
	input  index_t rd_index,
	input  tag_t   rd_tag,
	// Fill side
	input  logic   wr_req,
	input  index_t wr_index,
	input  tag_t   wr_tag,
	// Results
	output logic   hit,
	output way_t   hit_way,
	output way_t   fill_way
);

	tag_entry_t [WAYS-1:0] entries [SETS];	// One packed row per set

	tag_entry_t [WAYS-1:0] rd_set;
	tag_entry_t [WAYS-1:0] wr_set;

	logic [AGE_TIMER_W-1:0] age_timer;
	logic                   age_wrap;
	logic                   touch;

	// Fill way candidates
	logic         fill_match;
	way_t         match_way;
	way_t         low_way;
	line_status_e low_status;

	assign rd_set = entries[rd_index];
	assign wr_set = entries[wr_index];

	assign age_wrap = (age_timer == '1);	// Last count before rollover
	assign touch    = rd_req && hit;

	// Hit check
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		// Walk down so the lowest matching way ends up selected
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (is_valid(rd_set[w].status) && (rd_set[w].tag == rd_tag)) begin
				hit     = 1'b1;
				hit_way = way_t'(w);
			end
		end
	end

	// Way already holding this tag
	always_comb begin
		fill_match = 1'b0;
		match_way  = '0;
		for (int w = WAYS - 1; w >= 0; w--) begin
			if (is_valid(wr_set[w].status) && (wr_set[w].tag == wr_tag)) begin
				fill_match = 1'b1;
				match_way  = way_t'(w);
			end
		end
	end

	// Lowest status, strict compare keeps the lowest way on ties
	always_comb begin
		low_way    = way_t'(WAYS - 1);	// All fresh falls back to way 3
		low_status = LINE_FRESH;
		for (int w = 0; w < WAYS; w++) begin
			if (wr_set[w].status < low_status) begin
				low_status = wr_set[w].status;
				low_way    = way_t'(w);
			end
		end
	end

	assign fill_way = fill_match ? match_way : low_way;

	// Ageing timer, frozen while the reader stalls
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_timer <= '0;
		end
		else if (iREMOVE) begin
			age_timer <= '0;
		end
		else if (!rd_busy) begin
			age_timer <= age_timer + 1'b1;
		end
	end

	// Entry updates
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int s = 0; s < SETS; s++) begin
				entries[s] <= {WAYS{ENTRY_CLEAR}};
			end
		end
		else if (iREMOVE) begin
			// Flush every set
			for (int s = 0; s < SETS; s++) begin
				entries[s] <= {WAYS{ENTRY_CLEAR}};
			end
		end
		else if (wr_req) begin
			// Fill wins over touch and ageing
			entries[wr_index][fill_way] <= '{status: LINE_FRESH, tag: wr_tag};
		end
		else if (!rd_busy) begin
			if (age_wrap) begin
				for (int s = 0; s < SETS; s++) begin
					for (int w = 0; w < WAYS; w++) begin
						entries[s][w].status <= age_status(entries[s][w].status);
					end
				end
			end
			// Later assignment overrides the ageing step of the hit line
			if (touch) begin
				entries[rd_index][hit_way].status <= LINE_FRESH;
			end
		end
	end

endmodule

//--- rtl/cache_tag_pkg.sv
//**************************************************
// Cache tag types
// Line status encoding and tag entries used
// for hit check and recency tracking
//**************************************************
package cache_tag_pkg;

	import cache_geometry_pkg::*;

	// Recency status, higher is more recently used
	typedef enum logic [1:0] {
		LINE_INVALID = 2'd0,
		LINE_OLD     = 2'd1,
		LINE_AGED    = 2'd2,
		LINE_FRESH   = 2'd3
	} line_status_e;

	// One way of one set, status on top
	typedef struct packed {
		line_status_e status;
		tag_t         tag;
	} tag_entry_t;

	localparam tag_entry_t ENTRY_CLEAR = '{status: LINE_INVALID, tag: '0};

	function automatic logic is_valid(line_status_e s);
		return s != LINE_INVALID;
	endfunction

	// One ageing step, OLD and INVALID stay put
	function automatic line_status_e age_status(line_status_e s);
		case (s)
			LINE_FRESH: return LINE_AGED;
			LINE_AGED:  return LINE_OLD;
			default:    return s;
		endcase
	endfunction

endpackage

//--- rtl/cache_geometry_pkg.sv
//**************************************************
// Cache geometry
// Widths, counts and address fields of the
// 4-way, 16-set L1 read cache with 64-byte lines
//**************************************************
package cache_geometry_pkg;

	// Address and line sizes
	localparam int ADDR_W      = 32;
	localparam int TAG_W       = 22;
	localparam int INDEX_W     = 4;
	localparam int SETS        = 16;
	localparam int WAYS        = 4;
	localparam int WAY_W       = 2;
	localparam int LINE_W      = 512;	// 64 bytes
	localparam int WORD_W      = 64;
	localparam int WORD_SEL_W  = 3;		// 8 words per line
	localparam int AGE_TIMER_W = 16;

	// Field positions: tag 31..10 | index 9..6 | word 5..3 | byte 2..0
	localparam int WORD_LSB  = 3;
	localparam int INDEX_LSB = WORD_LSB + WORD_SEL_W;
	localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [INDEX_W-1:0]    index_t;
	typedef logic [WAY_W-1:0]      way_t;
	typedef logic [LINE_W-1:0]     line_t;
	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [WORD_SEL_W-1:0] word_sel_t;

endpackage
